/* logic/cw_reg_file.sv */
`timescale 1ns/1ns

module cw_reg_file
	import cw_route_pkg::*;
#(
	parameter reg_addr_t ADDR_TRIGSRC  = DEF_ADDR_TRIGSRC,
	parameter reg_addr_t ADDR_TRIGMOD  = DEF_ADDR_TRIGMOD,
	parameter reg_addr_t ADDR_IOROUTE  = DEF_ADDR_IOROUTE,
	parameter reg_len_t  IOROUTE_BYTES = 16'd8
) (
	input  logic      clk,
	input  logic      reset,

	// register bus
	input  reg_addr_t reg_address_i,
	input  byte_idx_t reg_bytecnt_i,     // byte within the routing register
	input  reg_byte_t reg_datai_i,
	input  logic      reg_read_i,
	input  logic      reg_write_i,
	input  logic      reg_addrvalid_i,
	output reg_byte_t reg_datao_o,

	// length lookup, independent of the access address
	input  reg_addr_t reg_hypaddress_i,
	output reg_len_t  reg_hyplen_o,

	// configuration out to the routing blocks
	output trig_src_t trig_src_o,
	output trig_mod_t trig_mod_o,
	output ioroute_t  ioroute_o
);

	trig_src_t trig_src_q;
	trig_mod_t trig_mod_q;
	ioroute_t  ioroute_q;

	reg_byte_t rd_byte_q;       // byte captured on a read
	logic      rd_valid_q;      // previous address was one of ours
	logic      addr_known;
	logic [5:0] byte_lsb;       // bit offset of the selected routing byte

	assign byte_lsb = {reg_bytecnt_i, 3'b000};

	// address decode shared by the read valid flag
	always_comb begin
		addr_known = 1'b0;
		case (reg_address_i)
			ADDR_TRIGSRC: addr_known = 1'b1;
			ADDR_TRIGMOD: addr_known = 1'b1;
			ADDR_IOROUTE: addr_known = 1'b1;
			default:      addr_known = 1'b0;
		endcase
	end

	// configuration registers, one byte per write pulse
	always_ff @(posedge clk) begin
		if (reset) begin
			trig_src_q <= RST_TRIGSRC;
			trig_mod_q <= RST_TRIGMOD;
			ioroute_q  <= RST_IOROUTE;
		end else if (reg_write_i) begin
			case (reg_address_i)
				ADDR_TRIGSRC: trig_src_q <= reg_datai_i;
				ADDR_TRIGMOD: trig_mod_q <= reg_datai_i;
				ADDR_IOROUTE: ioroute_q[byte_lsb +: 8] <= reg_datai_i;  // only the addressed byte
				default: ;                                              // not ours, ignore
			endcase
		end
	end

	// read data, valid from the cycle after the read strobe
	always_ff @(posedge clk) begin
		if (reg_read_i) begin
			case (reg_address_i)
				ADDR_TRIGSRC: rd_byte_q <= trig_src_q;
				ADDR_TRIGMOD: rd_byte_q <= trig_mod_q;
				ADDR_IOROUTE: rd_byte_q <= ioroute_q[byte_lsb +: 8];
				default:      rd_byte_q <= '0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_valid_q <= 1'b0;
		end else begin
			rd_valid_q <= reg_addrvalid_i & addr_known;   // drops as soon as the master lets go
		end
	end

	// shared bus, so stay quiet unless the last address hit here
	assign reg_datao_o = rd_valid_q ? rd_byte_q : '0;

	// register length lookup
	always_comb begin
		case (reg_hypaddress_i)
			ADDR_TRIGSRC: reg_hyplen_o = reg_len_t'(1);
			ADDR_TRIGMOD: reg_hyplen_o = reg_len_t'(1);
			ADDR_IOROUTE: reg_hyplen_o = IOROUTE_BYTES;
			default:      reg_hyplen_o = '0;                // unknown address, no length
		endcase
	end

	assign trig_src_o = trig_src_q;
	assign trig_mod_o = trig_mod_q;
	assign ioroute_o  = ioroute_q;

endmodule

/* logic/cw_route_pkg.sv */
package cw_route_pkg;

	// register bus widths
	typedef logic [5:0]  reg_addr_t;   // register address
	typedef logic [7:0]  reg_byte_t;   // one data byte on the bus
	typedef logic [2:0]  byte_idx_t;   // byte index inside a multi-byte register
	typedef logic [15:0] reg_len_t;    // register length in bytes

	// configuration register images
	typedef logic [7:0]  trig_src_t;   // [7:6] combine mode, [5:0] source enables
	typedef logic [7:0]  trig_mod_t;   // [4] fpb out, [3] fpa out, [2:0] module
	typedef logic [63:0] ioroute_t;    // eight routing bytes
	typedef logic [7:0]  gpio_cfg_t;   // one routing byte for a single pin

	// fields inside the trigger registers
	typedef logic [1:0]  comb_mode_t;
	typedef logic [2:0]  trigmod_sel_t;

	localparam int TS_NUM_SRC  = 6;    // fpa, fpb, io1..io4
	localparam int TS_MODE_LSB = 6;    // combine mode sits above the enables
	localparam int TM_FPA      = 3;
	localparam int TM_FPB      = 4;

	localparam comb_mode_t COMB_OR  = 2'd0;
	localparam comb_mode_t COMB_AND = 2'd1;   // codes 2 and 3 give a constant 0

	localparam trigmod_sel_t TRIGMOD_EXT    = 3'd0;
	localparam trigmod_sel_t TRIGMOD_ADVIO  = 3'd1;
	localparam trigmod_sel_t TRIGMOD_ANAPAT = 3'd2;

	// bit positions inside a gpio routing byte
	localparam int IOR_TX    = 0;
	localparam int IOR_RX    = 1;
	localparam int IOR_USIO  = 2;
	localparam int IOR_USII  = 3;
	localparam int IOR_USOC  = 4;      // pin 3 only
	localparam int IOR_TXOC  = 5;      // pin 3 only
	localparam int IOR_LEVEL = 6;
	localparam int IOR_DRIVE = 7;

	// target io pins, and how many of them can carry usi
	localparam int TIO_PINS = 4;
	localparam int USI_PINS = 3;

	// byte 4 holds glitch bits that nothing here uses
	localparam int IOR_BYTE_EXTRA = 5;
	localparam int EXTRA_AVRPROG  = 0;
	localparam int EXTRA_PWROFF   = 1;

	localparam reg_addr_t DEF_ADDR_TRIGSRC = 6'd39;
	localparam reg_addr_t DEF_ADDR_TRIGMOD = 6'd40;
	localparam reg_addr_t DEF_ADDR_IOROUTE = 6'd55;

	localparam trig_src_t RST_TRIGSRC = 8'h01;    // OR mode, front panel A only
	localparam trig_mod_t RST_TRIGMOD = 8'h00;
	localparam ioroute_t  RST_IOROUTE = 64'h0000_0000_0000_0201;   // tx on gpio1, rx from gpio2

endpackage

/* logic/cw_route_top.sv */
`timescale 1ns/1ns

module cw_route_top
	import cw_route_pkg::*;
#(
	parameter reg_addr_t ADDR_TRIGSRC  = DEF_ADDR_TRIGSRC,
	parameter reg_addr_t ADDR_TRIGMOD  = DEF_ADDR_TRIGMOD,
	parameter reg_addr_t ADDR_IOROUTE  = DEF_ADDR_IOROUTE,
	parameter reg_len_t  IOROUTE_BYTES = 16'd8    // reported length of the routing register
) (
	input  logic                clk,
	input  logic                reset,

	// register bus
	input  reg_addr_t           reg_address_i,
	input  byte_idx_t           reg_bytecnt_i,
	input  reg_byte_t           reg_datai_i,
	input  logic                reg_read_i,
	input  logic                reg_write_i,
	input  logic                reg_addrvalid_i,
	output reg_byte_t           reg_datao_o,
	input  reg_addr_t           reg_hypaddress_i,
	output reg_len_t            reg_hyplen_o,

	// trigger lines
	input  logic                trigger_fpa_i,
	input  logic                trigger_fpb_i,
	input  logic [3:0]          trigger_io_i,
	input  logic                trigger_advio_i,
	input  logic                trigger_anapattern_i,
	output logic                trigger_o,
	output logic                trigger_ext_o,
	output logic                trigger_fpa_o,
	output logic                trigger_fpa_oe_o,
	output logic                trigger_fpb_o,
	output logic                trigger_fpb_oe_o,

	// target io
	input  logic [TIO_PINS-1:0] targetio_i,
	output logic [TIO_PINS-1:0] targetio_o,
	output logic [TIO_PINS-1:0] targetio_oe_o,
	input  logic                uart_tx_i,
	output logic                uart_rx_o,
	input  logic                usi_out_i,
	output logic                usi_in_o,
	output logic                enable_avrprog_o,
	output logic                targetpower_off_o
);

	// configuration from the register file
	trig_src_t trig_src;
	trig_mod_t trig_mod;
	ioroute_t  ioroute;

	cw_reg_file #(
		.ADDR_TRIGSRC  (ADDR_TRIGSRC),
		.ADDR_TRIGMOD  (ADDR_TRIGMOD),
		.ADDR_IOROUTE  (ADDR_IOROUTE),
		.IOROUTE_BYTES (IOROUTE_BYTES)
	) i_cw_reg_file (
		.clk              (clk),
		.reset            (reset),
		.reg_address_i    (reg_address_i),
		.reg_bytecnt_i    (reg_bytecnt_i),
		.reg_datai_i      (reg_datai_i),
		.reg_read_i       (reg_read_i),
		.reg_write_i      (reg_write_i),
		.reg_addrvalid_i  (reg_addrvalid_i),
		.reg_datao_o      (reg_datao_o),
		.reg_hypaddress_i (reg_hypaddress_i),
		.reg_hyplen_o     (reg_hyplen_o),
		.trig_src_o       (trig_src),
		.trig_mod_o       (trig_mod),
		.ioroute_o        (ioroute)
	);

	// trigger path, registered inside
	trigger_combine i_trigger_combine (
		.clk                  (clk),
		.reset                (reset),
		.trig_src_i           (trig_src),
		.trig_mod_i           (trig_mod),
		.trigger_fpa_i        (trigger_fpa_i),
		.trigger_fpb_i        (trigger_fpb_i),
		.trigger_io_i         (trigger_io_i),
		.trigger_advio_i      (trigger_advio_i),
		.trigger_anapattern_i (trigger_anapattern_i),
		.trigger_o            (trigger_o),
		.trigger_ext_o        (trigger_ext_o),
		.trigger_fpa_o        (trigger_fpa_o),
		.trigger_fpa_oe_o     (trigger_fpa_oe_o),
		.trigger_fpb_o        (trigger_fpb_o),
		.trigger_fpb_oe_o     (trigger_fpb_oe_o)
	);

	// pin routing, purely combinational
	target_io_route i_target_io_route (
		.ioroute_i         (ioroute),
		.targetio_i        (targetio_i),
		.targetio_o        (targetio_o),
		.targetio_oe_o     (targetio_oe_o),
		.uart_tx_i         (uart_tx_i),
		.uart_rx_o         (uart_rx_o),
		.usi_out_i         (usi_out_i),
		.usi_in_o          (usi_in_o),
		.enable_avrprog_o  (enable_avrprog_o),
		.targetpower_off_o (targetpower_off_o)
	);

endmodule

/* logic/target_io_route.sv */
`timescale 1ns/1ns

module target_io_route
	import cw_route_pkg::*;
(
	input  ioroute_t            ioroute_i,

	// target io pins, split into in, out and enable
	input  logic [TIO_PINS-1:0] targetio_i,
	output logic [TIO_PINS-1:0] targetio_o,
	output logic [TIO_PINS-1:0] targetio_oe_o,

	input  logic                uart_tx_i,
	output logic                uart_rx_o,

	input  logic                usi_out_i,
	output logic                usi_in_o,

	output logic                enable_avrprog_o,
	output logic                targetpower_off_o   // 1 switches target power off
);

	gpio_cfg_t pin_cfg [TIO_PINS];   // routing byte per pin
	gpio_cfg_t extra_cfg;

	// bytes 0..3 map onto pins 1..4
	for (genvar g = 0; g < TIO_PINS; g++) begin : g_cfg
		assign pin_cfg[g] = ioroute_i[g*8 +: 8];
	end

	assign extra_cfg = ioroute_i[IOR_BYTE_EXTRA*8 +: 8];

	// drive side, first match wins per pin
	always_comb begin
		for (int i = 0; i < TIO_PINS; i++) begin
			targetio_o[i]    = 1'b0;
			targetio_oe_o[i] = 1'b0;                       // released by default
			if (pin_cfg[i][IOR_TX]) begin
				targetio_o[i]    = uart_tx_i;
				targetio_oe_o[i] = 1'b1;
			end else if (i < USI_PINS && pin_cfg[i][IOR_USIO]) begin
				targetio_o[i]    = usi_out_i;
				targetio_oe_o[i] = 1'b1;
			end else if (i == 2 && pin_cfg[i][IOR_USOC]) begin
				targetio_oe_o[i] = ~usi_out_i;             // open collector, pull low only
			end else if (i == 2 && pin_cfg[i][IOR_TXOC]) begin
				targetio_oe_o[i] = ~uart_tx_i;
			end else if (pin_cfg[i][IOR_DRIVE]) begin
				targetio_o[i]    = pin_cfg[i][IOR_LEVEL];  // static level
				targetio_oe_o[i] = 1'b1;
			end
		end
	end

	// receive side, walk down so the lowest pin is the one left standing
	always_comb begin
		uart_rx_o = 1'b1;                                  // uart idle when nothing routed
		for (int i = TIO_PINS - 1; i >= 0; i--) begin
			if (pin_cfg[i][IOR_RX]) begin
				uart_rx_o = targetio_i[i];
			end
		end
	end

	always_comb begin
		usi_in_o = 1'b1;
		for (int i = USI_PINS - 1; i >= 0; i--) begin     // usi input only on pins 1..3
			if (pin_cfg[i][IOR_USII]) begin
				usi_in_o = targetio_i[i];
			end
		end
	end

	// extra byte, straight through
	assign enable_avrprog_o  = extra_cfg[EXTRA_AVRPROG];
	assign targetpower_off_o = extra_cfg[EXTRA_PWROFF];

endmodule

/* logic/trigger_combine.sv */
`timescale 1ns/1ns

module trigger_combine
	import cw_route_pkg::*;
(
	input  logic      clk,
	input  logic      reset,

	input  trig_src_t trig_src_i,
	input  trig_mod_t trig_mod_i,

	// external trigger lines
	input  logic       trigger_fpa_i,      // front panel A, sampled directly
	input  logic       trigger_fpb_i,
	input  logic [3:0] trigger_io_i,       // rear target io lines 1..4

	// other trigger modules
	input  logic      trigger_advio_i,
	input  logic      trigger_anapattern_i,

	output logic      trigger_o,           // to the capture system
	output logic      trigger_ext_o,       // combined external trigger only

	// front panel echo
	output logic      trigger_fpa_o,
	output logic      trigger_fpa_oe_o,
	output logic      trigger_fpb_o,
	output logic      trigger_fpb_oe_o
);

	logic [TS_NUM_SRC-1:0] src;          // all external lines, same order as the enables
	logic [TS_NUM_SRC-1:0] src_en;
	comb_mode_t            comb_mode;
	trigmod_sel_t          mod_sel;

	logic trig_or;
	logic trig_and;
	logic trig_ext;
	logic trig_sel;

	assign src       = {trigger_io_i, trigger_fpb_i, trigger_fpa_i};
	assign src_en    = trig_src_i[TS_NUM_SRC-1:0];
	assign comb_mode = trig_src_i[TS_MODE_LSB +: 2];
	assign mod_sel   = trig_mod_i[2:0];

	assign trig_or  = |(src & src_en);
	assign trig_and = &(src | ~src_en);   // a disabled line never blocks, so none enabled gives 1

	always_comb begin
		case (comb_mode)
			COMB_OR:  trig_ext = trig_or;
			COMB_AND: trig_ext = trig_and;
			default:  trig_ext = 1'b0;
		endcase
	end

	// which module feeds the capture trigger
	always_comb begin
		case (mod_sel)
			TRIGMOD_EXT:    trig_sel = trig_ext;
			TRIGMOD_ADVIO:  trig_sel = trigger_advio_i;
			TRIGMOD_ANAPAT: trig_sel = trigger_anapattern_i;
			default:        trig_sel = 1'b0;    // unused module codes
		endcase
	end

	// one cycle of latency on both trigger outputs
	always_ff @(posedge clk) begin
		if (reset) begin
			trigger_o     <= 1'b0;
			trigger_ext_o <= 1'b0;
		end else begin
			trigger_o     <= trig_sel;
			trigger_ext_o <= trig_ext;
		end
	end

	// echo of the registered trigger, each panel enabled by its own bit
	assign trigger_fpa_o    = trigger_o;
	assign trigger_fpa_oe_o = trig_mod_i[TM_FPA];
	assign trigger_fpb_o    = trigger_o;
	assign trigger_fpb_oe_o = trig_mod_i[TM_FPB];

endmodule

/* sim/tb_cw_route_table.svh */
	// columns: op, addr, bytecnt, data, trig_in, pin_in, checks, exp data or length,
	// exp trig {fpb_oe, fpa_oe, ext, trig}, exp pins {oe, out}, exp misc {pwr, avr, usi, rx}
	task automatic load_table;
		add_row(OP_RD,  39, 0, 'h00, 'h00, 'h00, CK_D, 'h0001, 'h0, 'h00, 'h0);  // reset values
		add_row(OP_RD,  40, 0, 'h00, 'h00, 'h00, CK_D, 'h0000, 'h0, 'h00, 'h0);
		add_row(OP_RD,  55, 0, 'h00, 'h00, 'h00, CK_D, 'h0001, 'h0, 'h00, 'h0);
		add_row(OP_RD,  55, 1, 'h00, 'h00, 'h00, CK_D, 'h0002, 'h0, 'h00, 'h0);
		add_row(OP_RD,  12, 0, 'h00, 'h00, 'h00, CK_D, 'h0000, 'h0, 'h00, 'h0);  // not ours
		add_row(OP_CHK, 39, 0, 'h00, 'h00, 'h00, CK_L, 'h0001, 'h0, 'h00, 'h0);
		add_row(OP_CHK, 40, 0, 'h00, 'h00, 'h00, CK_L, 'h0001, 'h0, 'h00, 'h0);
		add_row(OP_CHK, 55, 0, 'h00, 'h00, 'h00, CK_L, 'h0008, 'h0, 'h00, 'h0);
		add_row(OP_CHK, 12, 0, 'h00, 'h00, 'h00, CK_L, 'h0000, 'h0, 'h00, 'h0);
		add_row(OP_CHK, 0,  0, 'h00, 'h01, 'h10, CK_T | CK_I, 'h0, 'h3, 'h11, 'h2);
		add_row(OP_WR,  39, 0, 'hA5, 'h00, 'h00, 0,    'h0000, 'h0, 'h00, 'h0);  // write and read back
		add_row(OP_RD,  39, 0, 'h00, 'h00, 'h00, CK_D, 'h00A5, 'h0, 'h00, 'h0);
		add_row(OP_WR,  40, 0, 'h1A, 'h00, 'h00, 0,    'h0000, 'h0, 'h00, 'h0);
		add_row(OP_RD,  40, 0, 'h00, 'h00, 'h00, CK_D, 'h001A, 'h0, 'h00, 'h0);
		add_row(OP_WR,  55, 3, 'h42, 'h00, 'h00, 0,    'h0000, 'h0, 'h00, 'h0);
		add_row(OP_WR,  55, 6, 'hC3, 'h00, 'h00, 0,    'h0000, 'h0, 'h00, 'h0);
		add_row(OP_RD,  55, 3, 'h00, 'h00, 'h00, CK_D, 'h0042, 'h0, 'h00, 'h0);
		add_row(OP_RD,  55, 6, 'h00, 'h00, 'h00, CK_D, 'h00C3, 'h0, 'h00, 'h0);
		add_row(OP_WR,  40, 0, 'h00, 'h00, 'h00, 0,    'h0000, 'h0, 'h00, 'h0);  // external module
		add_row(OP_WR,  39, 0, 'h7F, 'h00, 'h00, 0,    'h0000, 'h0, 'h00, 'h0);  // AND over all six
		add_row(OP_CHK, 39, 0, 'h00, 'h3F, 'h00, CK_T, 'h0000, 'h3, 'h00, 'h0);
		add_row(OP_CHK, 39, 0, 'h00, 'h3E, 'h00, CK_T, 'h0000, 'h0, 'h00, 'h0);
		add_row(OP_WR,  39, 0, 'h40, 'h00, 'h00, 0,    'h0000, 'h0, 'h00, 'h0);  // AND, nothing enabled
		add_row(OP_CHK, 39, 0, 'h00, 'h00, 'h00, CK_T, 'h0000, 'h3, 'h00, 'h0);
		add_row(OP_WR,  39, 0, 'h85, 'h00, 'h00, 0,    'h0000, 'h0, 'h00, 'h0);  // mode 2
		add_row(OP_CHK, 39, 0, 'h00, 'h3F, 'h00, CK_T, 'h0000, 'h0, 'h00, 'h0);
		add_row(OP_WR,  39, 0, 'h00, 'h00, 'h00, 0,    'h0000, 'h0, 'h00, 'h0);
		add_row(OP_WR,  40, 0, 'h09, 'h00, 'h00, 0,    'h0000, 'h0, 'h00, 'h0);  // advio, echo on fpa
		add_row(OP_CHK, 40, 0, 'h00, 'h40, 'h00, CK_T, 'h0000, 'h5, 'h00, 'h0);
		add_row(OP_WR,  40, 0, 'h12, 'h00, 'h00, 0,    'h0000, 'h0, 'h00, 'h0);  // anapat, echo on fpb
		add_row(OP_CHK, 40, 0, 'h00, 'h80, 'h00, CK_T, 'h0000, 'h9, 'h00, 'h0);
		add_row(OP_WR,  40, 0, 'h05, 'h00, 'h00, 0,    'h0000, 'h0, 'h00, 'h0);  // unused code
		add_row(OP_CHK, 40, 0, 'h00, 'hFF, 'h00, CK_T, 'h0000, 'h0, 'h00, 'h0);
		add_row(OP_WR,  55, 0, 'h05, 'h00, 'h00, 0,    'h0000, 'h0, 'h00, 'h0);  // pin1 tx and usio
		add_row(OP_WR,  55, 1, 'hC0, 'h00, 'h00, 0,    'h0000, 'h0, 'h00, 'h0);  // pin2 static high
		add_row(OP_WR,  55, 2, 'h10, 'h00, 'h00, 0,    'h0000, 'h0, 'h00, 'h0);  // pin3 usi open collector
		add_row(OP_CHK, 55, 0, 'h00, 'h00, 'h10, CK_I, 'h0000, 'h0, 'h73, 'h2);
		add_row(OP_CHK, 55, 0, 'h00, 'h00, 'h28, CK_I, 'h0000, 'h0, 'h32, 'h3);
		add_row(OP_WR,  55, 2, 'h12, 'h00, 'h00, 0,    'h0000, 'h0, 'h00, 'h0);  // rx on pin3 and pin4
		add_row(OP_CHK, 55, 0, 'h00, 'h00, 'h38, CK_I, 'h0000, 'h0, 'h33, 'h2);
		add_row(OP_WR,  55, 1, 'hC8, 'h00, 'h00, 0,    'h0000, 'h0, 'h00, 'h0);  // usi in from pin2
		add_row(OP_CHK, 55, 0, 'h00, 'h00, 'h31, CK_I, 'h0000, 'h0, 'h33, 'h0);
		add_row(OP_WR,  55, 2, 'h10, 'h00, 'h00, 0,    'h0000, 'h0, 'h00, 'h0);
		add_row(OP_WR,  55, 3, 'h00, 'h00, 'h00, 0,    'h0000, 'h0, 'h00, 'h0);  // no rx pin left
		add_row(OP_CHK, 55, 0, 'h00, 'h00, 'h3C, CK_I, 'h0000, 'h0, 'h33, 'h1);
		add_row(OP_WR,  55, 5, 'h01, 'h00, 'h00, 0,    'h0000, 'h0, 'h00, 'h0);  // extra byte
		add_row(OP_CHK, 55, 0, 'h00, 'h00, 'h30, CK_I, 'h0000, 'h0, 'h33, 'h5);
		add_row(OP_WR,  55, 5, 'h02, 'h00, 'h00, 0,    'h0000, 'h0, 'h00, 'h0);
		add_row(OP_CHK, 55, 0, 'h00, 'h00, 'h30, CK_T | CK_I, 'h0, 'h0, 'h33, 'h9);
		add_row(OP_WR,  55, 4, 'hFF, 'h00, 'h00, 0,    'h0000, 'h0, 'h00, 'h0);  // glitch byte
		add_row(OP_CHK, 55, 0, 'h00, 'h00, 'h30, CK_T | CK_I, 'h0, 'h0, 'h33, 'h9);
	endtask

/* sim/tb_cw_route.sv */
`timescale 1ns/1ns

module tb_cw_route
	import cw_route_pkg::*;
();

	localparam int CLK_PERIOD = 10;
	localparam int N_RANDOM   = 12;     // random combine cases after the table

	localparam logic [1:0] OP_WR  = 2'd0;
	localparam logic [1:0] OP_RD  = 2'd1;
	localparam logic [1:0] OP_CHK = 2'd2;   // settle and compare, no bus access

	localparam logic [3:0] CK_D = 4'b0001;  // read data
	localparam logic [3:0] CK_L = 4'b0010;  // register length
	localparam logic [3:0] CK_T = 4'b0100;  // triggers and front panel
	localparam logic [3:0] CK_I = 4'b1000;  // target io, rx, usi, extra bits

	typedef struct packed {
		logic [1:0]  op;
		logic [5:0]  addr;
		logic [2:0]  bcnt;
		logic [7:0]  data;
		logic [7:0]  trig_in;   // {anapat, advio, io4..io1, fpb, fpa}
		logic [7:0]  pin_in;    // {unused, usi_out, uart_tx, targetio[3:0]}
		logic [3:0]  chk;
		logic [15:0] exp_data;  // read byte or length
		logic [3:0]  exp_trig;
		logic [7:0]  exp_pins;
		logic [3:0]  exp_misc;
	} row_t;

	row_t   rows [$];
	logic   rows_ready;
	integer seed;

	logic      clk;
	logic      reset;
	reg_addr_t reg_address_i;
	reg_addr_t reg_hypaddress_i;
	byte_idx_t reg_bytecnt_i;
	reg_byte_t reg_datai_i;
	logic      reg_read_i, reg_write_i, reg_addrvalid_i;
	reg_byte_t reg_datao_o;
	reg_len_t  reg_hyplen_o;
	logic       trigger_fpa_i, trigger_fpb_i, trigger_advio_i, trigger_anapattern_i;
	logic [3:0] trigger_io_i;
	logic       trigger_o, trigger_ext_o;
	logic       trigger_fpa_o, trigger_fpa_oe_o, trigger_fpb_o, trigger_fpb_oe_o;
	logic [3:0] targetio_i, targetio_o, targetio_oe_o;
	logic       uart_tx_i, uart_rx_o, usi_out_i, usi_in_o;
	logic       enable_avrprog_o, targetpower_off_o;

	cw_route_top i_cw_route_top (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic add_row(input logic [1:0] op, input logic [5:0] addr, input logic [2:0] bcnt,
			input logic [7:0] data, input logic [7:0] trig_in, input logic [7:0] pin_in,
			input logic [3:0] chk, input logic [15:0] exp_data, input logic [3:0] exp_trig,
			input logic [7:0] exp_pins, input logic [3:0] exp_misc);
		row_t r;
		r = {op, addr, bcnt, data, trig_in, pin_in, chk, exp_data, exp_trig, exp_pins, exp_misc};
		rows.push_back(r);
	endtask

	`include "tb_cw_route_table.svh"

	// OR of the enabled lines, or AND where a disabled line counts as high
	function automatic logic expect_ext(input logic [1:0] mode, input logic [5:0] en,
			input logic [5:0] lines);
		logic any_hi;
		logic all_hi;
		any_hi = 1'b0;
		all_hi = 1'b1;
		for (int i = 0; i < 6; i++) begin
			if (en[i]) begin
				any_hi = any_hi | lines[i];
				all_hi = all_hi & lines[i];
			end
		end
		if (mode == COMB_OR) begin
			return any_hi;
		end else if (mode == COMB_AND) begin
			return all_hi;
		end
		return 1'b0;
	endfunction

	task automatic add_random_rows;
		integer     rnd;
		logic [1:0] mode;
		logic       res;
		add_row(OP_WR, 40, 0, 'h00, 'h00, 'h00, 0, 0, 0, 0, 0);   // external module, no echo
		for (int k = 0; k < N_RANDOM; k++) begin
			rnd  = $random(seed);
			mode = rnd[0] ? COMB_AND : COMB_OR;
			res  = expect_ext(mode, rnd[13:8], rnd[21:16]);
			add_row(OP_WR, 39, 0, {mode, rnd[13:8]}, 'h00, 'h00, 0, 0, 0, 0, 0);
			add_row(OP_CHK, 39, 0, 'h00, rnd[23:16], 'h00, CK_T, 0, {2'b00, res, res}, 0, 0);
		end
	endtask

	task automatic check_value(input string name, input logic [15:0] actual,
			input logic [15:0] expected);
		if (actual !== expected) begin
			$display("Error at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
			$display("Testbench failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// drive one row, let the DUT take it at the next edge, compare mid-cycle
	task automatic apply_row(input row_t r);
		@(posedge clk);
		reg_address_i    <= r.addr;
		reg_hypaddress_i <= r.addr;
		reg_bytecnt_i    <= r.bcnt;
		reg_datai_i      <= r.data;
		reg_write_i      <= (r.op == OP_WR);
		reg_read_i       <= (r.op == OP_RD);
		reg_addrvalid_i  <= (r.op == OP_RD);
		{trigger_anapattern_i, trigger_advio_i, trigger_io_i} <= r.trig_in[7:2];
		{trigger_fpb_i, trigger_fpa_i} <= r.trig_in[1:0];
		{usi_out_i, uart_tx_i, targetio_i} <= r.pin_in[5:0];
		@(posedge clk);
		reg_write_i      <= 1'b0;   // bus strobes last a single cycle
		reg_read_i       <= 1'b0;
		reg_addrvalid_i  <= 1'b0;
		@(negedge clk);
		if (r.chk & CK_D) begin
			check_value("reg_datao_o", reg_datao_o, r.exp_data);
		end
		if (r.chk & CK_L) begin
			check_value("reg_hyplen_o", reg_hyplen_o, r.exp_data);
		end
		if (r.chk & CK_T) begin
			check_value("trigger_o", trigger_o, r.exp_trig[0]);
			check_value("trigger_ext_o", trigger_ext_o, r.exp_trig[1]);
			check_value("trigger_fpa_oe_o", trigger_fpa_oe_o, r.exp_trig[2]);
			check_value("trigger_fpb_oe_o", trigger_fpb_oe_o, r.exp_trig[3]);
			check_value("trigger_fpa_o", trigger_fpa_o, r.exp_trig[0]);  // echo of trigger_o
			check_value("trigger_fpb_o", trigger_fpb_o, r.exp_trig[0]);
		end
		if (r.chk & CK_I) begin
			check_value("targetio_oe_o", targetio_oe_o, r.exp_pins[7:4]);
			check_value("targetio_o", targetio_o & r.exp_pins[7:4],
				r.exp_pins[3:0] & r.exp_pins[7:4]);                     // driven pins only
			check_value("uart_rx_o", uart_rx_o, r.exp_misc[0]);
			check_value("usi_in_o", usi_in_o, r.exp_misc[1]);
			check_value("enable_avrprog_o", enable_avrprog_o, r.exp_misc[2]);
			check_value("targetpower_off_o", targetpower_off_o, r.exp_misc[3]);
		end
	endtask

	initial begin
		seed = 92;
		rows_ready = 1'b0;
		clk = 1'b0;
		reset = 1'b1;
		reg_address_i = '0;
		reg_hypaddress_i = '0;
		reg_bytecnt_i = '0;
		reg_datai_i = '0;
		reg_read_i = 1'b0;
		reg_write_i = 1'b0;
		reg_addrvalid_i = 1'b0;
		{trigger_fpa_i, trigger_fpb_i, trigger_advio_i, trigger_anapattern_i} = 4'b0000;
		trigger_io_i = 4'b0000;
		targetio_i = 4'b0000;
		uart_tx_i = 1'b0;
		usi_out_i = 1'b0;
		load_table();
		add_random_rows();
		rows_ready = 1'b1;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		for (int i = 0; i < rows.size(); i++) begin
			apply_row(rows[i]);
		end
		$display("Testbench passed");
		$finish;
	end

	// each row takes two cycles, so four per row leaves room
	initial begin
		wait (rows_ready);
		repeat (rows.size() * 4 + 20) @(posedge clk);
		$display("Timeout: the table did not finish in time");
		$display("Testbench failed");
		$fatal(1, "watchdog expired");
	end

endmodule

/* sources.f */
+incdir+sim
logic/cw_route_pkg.sv
logic/cw_reg_file.sv
logic/trigger_combine.sv
logic/target_io_route.sv
logic/cw_route_top.sv
sim/tb_cw_route.sv
